//--- design/control_merge.sv
// PS/2 key state decoder and keyboard/joystick merge for four players
`timescale 1ns/1ps
`include "mcr3_input_cfg.svh"

module control_merge import mcr3_ctrl_pkg::*; (
        input  logic         clk_sys,
        input  logic         reset,
        input  ps2_event_t   ps2_key,
        input  joy_t         joystick_0,
        input  joy_t         joystick_1,
        input  joy_t         joystick_2,
        input  joy_t         joystick_3,
        output player_ctrl_t p1_ctrl,
        output player_ctrl_t p2_ctrl,
        output player_ctrl_t p3_ctrl,
        output player_ctrl_t p4_ctrl
);

        logic       toggle_last;
        logic       new_event;
        logic [7:0] p1_keys;     // Up, down, left, right, fire A to D
        logic [7:0] p2_keys;
        logic [3:0] start_fkey;  // F1 to F4
        logic [3:0] start_digit; // 1 to 4
        logic [3:0] coin_digit;  // 5 to 8
        logic       coin_esc;

        assign new_event = ps2_key.toggle != toggle_last;

        // ==============================
        // Key states
        // ==============================
        always_ff @(posedge clk_sys) begin
                toggle_last <= ps2_key.toggle;
                if (reset) begin
                        p1_keys     <= '0;
                        p2_keys     <= '0;
                        start_fkey  <= '0;
                        start_digit <= '0;
                        coin_digit  <= '0;
                        coin_esc    <= 1'b0;
                end else if (new_event) begin
                        case (ps2_key.code)
                        `KEY_UP:     p1_keys[7]     <= ps2_key.pressed;
                        `KEY_DOWN:   p1_keys[6]     <= ps2_key.pressed;
                        `KEY_LEFT:   p1_keys[5]     <= ps2_key.pressed;
                        `KEY_RIGHT:  p1_keys[4]     <= ps2_key.pressed;
                        `KEY_SPACE:  p1_keys[3]     <= ps2_key.pressed;
                        `KEY_ALT:    p1_keys[2]     <= ps2_key.pressed;
                        `KEY_CTRL:   p1_keys[1]     <= ps2_key.pressed;
                        `KEY_LSHIFT: p1_keys[0]     <= ps2_key.pressed;
                        `KEY_R:      p2_keys[7]     <= ps2_key.pressed;
                        `KEY_F:      p2_keys[6]     <= ps2_key.pressed;
                        `KEY_D:      p2_keys[5]     <= ps2_key.pressed;
                        `KEY_G:      p2_keys[4]     <= ps2_key.pressed;
                        `KEY_A:      p2_keys[3]     <= ps2_key.pressed;
                        `KEY_S:      p2_keys[2]     <= ps2_key.pressed;
                        `KEY_Q:      p2_keys[1]     <= ps2_key.pressed;
                        `KEY_W:      p2_keys[0]     <= ps2_key.pressed;
                        `KEY_F1:     start_fkey[0]  <= ps2_key.pressed;
                        `KEY_F2:     start_fkey[1]  <= ps2_key.pressed;
                        `KEY_F3:     start_fkey[2]  <= ps2_key.pressed;
                        `KEY_F4:     start_fkey[3]  <= ps2_key.pressed;
                        `KEY_1:      start_digit[0] <= ps2_key.pressed;
                        `KEY_2:      start_digit[1] <= ps2_key.pressed;
                        `KEY_3:      start_digit[2] <= ps2_key.pressed;
                        `KEY_4:      start_digit[3] <= ps2_key.pressed;
                        `KEY_5:      coin_digit[0]  <= ps2_key.pressed;
                        `KEY_6:      coin_digit[1]  <= ps2_key.pressed;
                        `KEY_7:      coin_digit[2]  <= ps2_key.pressed;
                        `KEY_8:      coin_digit[3]  <= ps2_key.pressed;
                        `KEY_ESC:    coin_esc       <= ps2_key.pressed;
                        default: ;   // Unmapped key
                        endcase
                end
        end

        // OR of keyboard and joystick for one player
        function automatic player_ctrl_t merge_ctrl(input joy_t joy, input logic [7:0] keys,
                                                    input logic start_key, input logic coin_key);
                player_ctrl_t c;
                c.up     = keys[7] | joy[`JOY_UP_BIT];
                c.down   = keys[6] | joy[`JOY_DOWN_BIT];
                c.left   = keys[5] | joy[`JOY_LEFT_BIT];
                c.right  = keys[4] | joy[`JOY_RIGHT_BIT];
                c.fire_a = keys[3] | joy[`JOY_FIRE_A_BIT];
                c.fire_b = keys[2] | joy[`JOY_FIRE_B_BIT];
                c.fire_c = keys[1] | joy[`JOY_FIRE_C_BIT];
                c.fire_d = keys[0] | joy[`JOY_FIRE_D_BIT];
                c.start  = start_key | joy[`JOY_START_BIT];
                c.coin   = coin_key | coin_esc | joy[`JOY_COIN_BIT];
                return c;
        endfunction

        // Players 3 and 4 get only start and coin keys
        assign p1_ctrl = merge_ctrl(joystick_0, p1_keys, start_fkey[0] | start_digit[0],
                                    coin_digit[0]);
        assign p2_ctrl = merge_ctrl(joystick_1, p2_keys, start_fkey[1] | start_digit[1],
                                    coin_digit[1]);
        assign p3_ctrl = merge_ctrl(joystick_2, 8'h00, start_fkey[2] | start_digit[2],
                                    coin_digit[2]);
        assign p4_ctrl = merge_ctrl(joystick_3, 8'h00, start_fkey[3] | start_digit[3],
                                    coin_digit[3]);

        // Key state only moves on a new keyboard event
        a_keys_need_event: assert property (@(posedge clk_sys) disable iff (reset)
                !new_event |=> $stable({p1_keys, p2_keys, start_fkey, start_digit,
                                        coin_digit, coin_esc}));

endmodule

//--- design/game_config.sv
// Game number and DIP byte 0 capture from the download stream
`timescale 1ns/1ps
`include "mcr3_input_cfg.svh"

module game_config import mcr3_game_pkg::*; (
        input  logic        clk_sys,
        input  logic        reset,
        input  logic        dl_wr,
        input  logic [7:0]  dl_index,
        input  logic [24:0] dl_addr,
        input  port_byte_t  dl_data,
        output game_id_t    game_id,
        output port_byte_t  dip0
);

        logic game_wr;
        logic dip_wr;

        assign game_wr = dl_wr && (dl_index == `DL_INDEX_GAME);
        assign dip_wr  = dl_wr && (dl_index == `DL_INDEX_DIP) && (dl_addr == 25'd0);

        always_ff @(posedge clk_sys) begin
                if (reset) begin
                        game_id <= game_rampage;
                        dip0    <= `PORT_IDLE;  // All switches off
                end else begin
                        if (game_wr)
                                game_id <= game_id_t'(dl_data[1:0]);
                        if (dip_wr)
                                dip0 <= dl_data;
                end
        end

        // Only four games exist in this family
        a_game_number_range: assert property (@(posedge clk_sys) disable iff (reset)
                game_wr |-> dl_data < 8'd4);

endmodule

//--- design/mcr3_ctrl_pkg.sv
// Player-control types: PS/2 event, joystick word, merged player controls
package mcr3_ctrl_pkg;

        // Event from the keyboard, new one on each toggle change
        typedef struct packed {
                logic       toggle;
                logic       pressed;
                logic [8:0] code;
        } ps2_event_t;

        typedef logic [15:0] joy_t;

        // One player's merged controls
        typedef struct packed {
                logic up;
                logic down;
                logic left;
                logic right;
                logic fire_a;
                logic fire_b;
                logic fire_c;
                logic fire_d;
                logic start;
                logic coin;
        } player_ctrl_t;

endpackage

//--- design/mcr3_game_pkg.sv
// Game identity, input port byte and gear state types
package mcr3_game_pkg;

        // Game number as sent in the download stream
        typedef enum logic [1:0] {
                game_rampage    = 2'd0,
                game_sarge      = 2'd1,
                game_powerdrive = 2'd2,
                game_maxrpm     = 2'd3
        } game_id_t;

        typedef logic [7:0] port_byte_t;   // Active-low input port

        typedef logic [2:0] maxrpm_gear_t; // Gear index 0 to 4

        typedef logic [2:0] pdrv_gear_t;   // One toggle bit per player

endpackage

//--- design/mcr3_input_cfg.svh
// Key codes, joystick bit positions, download indices and gear constants
`ifndef MCR3_INPUT_CFG_SVH
`define MCR3_INPUT_CFG_SVH

// ==============================
// PS/2 set 2 key codes
// ==============================
`define KEY_UP          9'h075
`define KEY_DOWN        9'h072
`define KEY_LEFT        9'h06B
`define KEY_RIGHT       9'h074
`define KEY_ESC         9'h076
`define KEY_F1          9'h005
`define KEY_F2          9'h006
`define KEY_F3          9'h004
`define KEY_F4          9'h00C
`define KEY_SPACE       9'h029  // Fire A, player 1
`define KEY_ALT         9'h011
`define KEY_CTRL        9'h014
`define KEY_LSHIFT      9'h012
`define KEY_1           9'h016
`define KEY_2           9'h01E
`define KEY_3           9'h026
`define KEY_4           9'h025
`define KEY_5           9'h02E
`define KEY_6           9'h036
`define KEY_7           9'h03D
`define KEY_8           9'h03E
`define KEY_R           9'h02D  // Player 2 stick
`define KEY_F           9'h02B
`define KEY_D           9'h023
`define KEY_G           9'h034
`define KEY_A           9'h01C  // Player 2 buttons
`define KEY_S           9'h01B
`define KEY_Q           9'h015
`define KEY_W           9'h01D

// Joystick word layout
`define JOY_RIGHT_BIT   0
`define JOY_LEFT_BIT    1
`define JOY_DOWN_BIT    2
`define JOY_UP_BIT      3
`define JOY_FIRE_A_BIT  4
`define JOY_FIRE_B_BIT  5
`define JOY_FIRE_C_BIT  6
`define JOY_FIRE_D_BIT  7
`define JOY_START_BIT   8
`define JOY_COIN_BIT    9

// Download stream
`define DL_INDEX_GAME   8'd1
`define DL_INDEX_DIP    8'd254

// Max RPM shifter
`define MAXRPM_GEAR_TOP 3'd4
`define MAXRPM_CODE_0   4'h0
`define MAXRPM_CODE_1   4'h5
`define MAXRPM_CODE_2   4'h6
`define MAXRPM_CODE_3   4'h1
`define MAXRPM_CODE_4   4'h2

`define PORT_IDLE       8'hFF   // No input active

`endif

//--- design/mcr3_input_top.sv
// Player-input front end: control merge, game config and port mapper
`timescale 1ns/1ps

module mcr3_input_top import mcr3_ctrl_pkg::*, mcr3_game_pkg::*; (
        input  logic        clk_sys,
        input  logic        reset,
        input  ps2_event_t  ps2_key,
        input  joy_t        joystick_0,
        input  joy_t        joystick_1,
        input  joy_t        joystick_2,
        input  joy_t        joystick_3,
        input  logic        dl_wr,
        input  logic [7:0]  dl_index,
        input  logic [24:0] dl_addr,
        input  port_byte_t  dl_data,
        input  logic        service,
        input  logic [1:0]  snd_stat,
        output port_byte_t  input0,
        output port_byte_t  input1,
        output port_byte_t  input2,
        output port_byte_t  input3,
        output port_byte_t  input4,
        output logic        sounds_good
);

        player_ctrl_t p1_ctrl;
        player_ctrl_t p2_ctrl;
        player_ctrl_t p3_ctrl;
        player_ctrl_t p4_ctrl;
        game_id_t     game_id;
        port_byte_t   dip0;

        control_merge control_merge_inst (
                .clk_sys    (clk_sys),
                .reset      (reset),
                .ps2_key    (ps2_key),
                .joystick_0 (joystick_0),
                .joystick_1 (joystick_1),
                .joystick_2 (joystick_2),
                .joystick_3 (joystick_3),
                .p1_ctrl    (p1_ctrl),
                .p2_ctrl    (p2_ctrl),
                .p3_ctrl    (p3_ctrl),
                .p4_ctrl    (p4_ctrl)
        );

        game_config game_config_inst (
                .clk_sys  (clk_sys),
                .reset    (reset),
                .dl_wr    (dl_wr),
                .dl_index (dl_index),
                .dl_addr  (dl_addr),
                .dl_data  (dl_data),
                .game_id  (game_id),
                .dip0     (dip0)
        );

        port_mapper port_mapper_inst (
                .clk_sys     (clk_sys),
                .reset       (reset),
                .p1_ctrl     (p1_ctrl),
                .p2_ctrl     (p2_ctrl),
                .p3_ctrl     (p3_ctrl),
                .p4_ctrl     (p4_ctrl),
                .game_id     (game_id),
                .dip0        (dip0),
                .service     (service),
                .snd_stat    (snd_stat),
                .input0      (input0),
                .input1      (input1),
                .input2      (input2),
                .input3      (input3),
                .input4      (input4),
                .sounds_good (sounds_good)
        );

endmodule

//--- design/port_mapper.sv
// Max RPM and Power Drive gear logic, per-game input port assembly
`timescale 1ns/1ps
`include "mcr3_input_cfg.svh"

module port_mapper import mcr3_ctrl_pkg::*, mcr3_game_pkg::*; (
        input  logic         clk_sys,
        input  logic         reset,
        input  player_ctrl_t p1_ctrl,
        input  player_ctrl_t p2_ctrl,
        input  player_ctrl_t p3_ctrl,
        input  player_ctrl_t p4_ctrl,
        input  game_id_t     game_id,
        input  port_byte_t   dip0,
        input  logic         service,
        input  logic [1:0]   snd_stat,
        output port_byte_t   input0,
        output port_byte_t   input1,
        output port_byte_t   input2,
        output port_byte_t   input3,
        output port_byte_t   input4,
        output logic         sounds_good
);

        player_ctrl_t p1_last;
        player_ctrl_t p2_last;
        player_ctrl_t p3_last;
        maxrpm_gear_t gear_1;
        maxrpm_gear_t gear_2;
        pdrv_gear_t   pdrv_gear;

        // Start wins, then shift up, then shift down
        function automatic maxrpm_gear_t step_gear(input maxrpm_gear_t gear,
                                                   input player_ctrl_t now,
                                                   input player_ctrl_t last);
                if (now.start)
                        return 3'd0;
                if (now.fire_a && !last.fire_a && gear != `MAXRPM_GEAR_TOP)
                        return gear + 3'd1;
                if (now.fire_b && !last.fire_b && gear != 3'd0)
                        return gear - 3'd1;
                return gear;
        endfunction

        function automatic logic [3:0] gear_code(input maxrpm_gear_t gear);
                case (gear)
                3'd1:    return `MAXRPM_CODE_1;
                3'd2:    return `MAXRPM_CODE_2;
                3'd3:    return `MAXRPM_CODE_3;
                3'd4:    return `MAXRPM_CODE_4;
                default: return `MAXRPM_CODE_0;
                endcase
        endfunction

        // ==============================
        // Gear state
        // ==============================
        always_ff @(posedge clk_sys) begin
                if (reset) begin
                        p1_last   <= '0;
                        p2_last   <= '0;
                        p3_last   <= '0;
                        gear_1    <= '0;
                        gear_2    <= '0;
                        pdrv_gear <= '0;
                end else begin
                        p1_last <= p1_ctrl;
                        p2_last <= p2_ctrl;
                        p3_last <= p3_ctrl;
                        gear_1  <= step_gear(gear_1, p1_ctrl, p1_last);
                        gear_2  <= step_gear(gear_2, p2_ctrl, p2_last);
                        // Power Drive low/high shifter per player
                        pdrv_gear <= pdrv_gear ^ ({p3_ctrl.fire_d, p2_ctrl.fire_d, p1_ctrl.fire_d}
                                & ~{p3_last.fire_d, p2_last.fire_d, p1_last.fire_d});
                end
        end

        // ==============================
        // Port assembly, all active low
        // ==============================
        always_comb begin
                input0      = `PORT_IDLE;
                input1      = `PORT_IDLE;
                input2      = `PORT_IDLE;
                input3      = dip0;
                input4      = `PORT_IDLE;
                sounds_good = !(game_id == game_sarge || game_id == game_maxrpm);
                case (game_id)
                game_rampage: begin
                        input0 = ~{2'b00, service, 3'b000, p2_ctrl.coin, p1_ctrl.coin};
                        input1 = ~{2'b00, p1_ctrl.fire_b, p1_ctrl.fire_a,
                                   p1_ctrl.left, p1_ctrl.down, p1_ctrl.right, p1_ctrl.up};
                        input2 = ~{2'b00, p2_ctrl.fire_b, p2_ctrl.fire_a,
                                   p2_ctrl.left, p2_ctrl.down, p2_ctrl.right, p2_ctrl.up};
                        input4 = ~{2'b00, p3_ctrl.fire_b, p3_ctrl.fire_a,
                                   p3_ctrl.left, p3_ctrl.down, p3_ctrl.right, p3_ctrl.up};
                end
                game_sarge: begin  // Twin stick, either button fires
                        input0 = ~{2'b00, service, 1'b0, p2_ctrl.start, p1_ctrl.start,
                                   p2_ctrl.coin, p1_ctrl.coin};
                        input1 = ~{{2{p1_ctrl.fire_a | p1_ctrl.fire_b}},
                                   {2{p2_ctrl.fire_a | p2_ctrl.fire_b}},
                                   p1_ctrl.down, p1_ctrl.up, p2_ctrl.down, p2_ctrl.up};
                        input2 = ~{{2{p3_ctrl.fire_a | p3_ctrl.fire_b}},
                                   {2{p4_ctrl.fire_a | p4_ctrl.fire_b}},
                                   p3_ctrl.down, p3_ctrl.up, p4_ctrl.down, p4_ctrl.up};
                end
                game_maxrpm: begin
                        input0 = ~{service, 3'b000, p1_ctrl.start, p2_ctrl.start,
                                   p1_ctrl.coin, p2_ctrl.coin};
                        input2 = ~{gear_code(gear_1), gear_code(gear_2)};
                end
                game_powerdrive: begin
                        input0 = ~{2'b00, service, 2'b00, p3_ctrl.coin, p2_ctrl.coin,
                                   p1_ctrl.coin};
                        input1 = ~{p2_ctrl.fire_b, p2_ctrl.fire_a, pdrv_gear[1], p2_ctrl.fire_c,
                                   p1_ctrl.fire_b, p1_ctrl.fire_a, pdrv_gear[0], p1_ctrl.fire_c};
                        input2 = ~{snd_stat[0], 3'b000, p3_ctrl.fire_b, p3_ctrl.fire_a,
                                   pdrv_gear[2], p3_ctrl.fire_c};
                end
                default: ;
                endcase
        end

        a_gear_in_range: assert property (@(posedge clk_sys) disable iff (reset)
                gear_1 <= `MAXRPM_GEAR_TOP && gear_2 <= `MAXRPM_GEAR_TOP);

endmodule

//--- dv/mcr3_input_tb.sv
// Directed testbench for the MCR3 player-input front end: stimulus, compare tasks, tests
`timescale 1ns/1ps
`include "mcr3_input_cfg.svh"

module mcr3_input_tb import mcr3_ctrl_pkg::*, mcr3_game_pkg::*;;

        logic        clk_sys;
        logic        reset;
        ps2_event_t  ps2_key;
        joy_t        joystick_0;
        joy_t        joystick_1;
        joy_t        joystick_2;
        joy_t        joystick_3;
        logic        dl_wr;
        logic [7:0]  dl_index;
        logic [24:0] dl_addr;
        port_byte_t  dl_data;
        logic        service;
        logic [1:0]  snd_stat;
        port_byte_t  input0;
        port_byte_t  input1;
        port_byte_t  input2;
        port_byte_t  input3;
        port_byte_t  input4;
        logic        sounds_good;

        int          err_port;
        int          err_flag;
        int          err_timeout;
        int          rpm_gear [2];                                    // Max RPM gear model
        logic [3:0]  rpm_code [5] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};  // Gear code table
        logic [2:0]  pd_gear;                                         // Power Drive model

        mcr3_input_top mcr3_input_top_inst (.*);

        initial begin
                clk_sys = 1'b0;
                forever #4 clk_sys = ~clk_sys;
        end

        // ==============================
        // Compare tasks
        // ==============================
        task automatic check_port(input string name, input port_byte_t got,
                                  input port_byte_t exp);
                if (got !== exp) begin
                        err_port++;
                        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        err_flag++;
                        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
                end
        endtask

        // ==============================
        // Stimulus helpers
        // ==============================
        task automatic next_cycle();
                @(negedge clk_sys);
        endtask

        task automatic wait_outputs_known();
                int n;
                n = 0;
                while ((^{input0, input1, input2, input3, input4, sounds_good}) === 1'bx) begin
                        if (n == 16) begin
                                err_timeout++;
                                $display("Timeout: DUT outputs still unknown after reset");
                                return;
                        end
                        next_cycle();
                        n++;
                end
        endtask

        // Also returns the level inputs to idle so each test starts clean
        task automatic apply_reset();
                reset      = 1'b1;
                joystick_0 = '0;
                joystick_1 = '0;
                joystick_2 = '0;
                joystick_3 = '0;
                service    = 1'b0;
                snd_stat   = 2'b00;
                for (int i = 0; i < 4; i++)
                        next_cycle();
                reset = 1'b0;
                wait_outputs_known();
        endtask

        task automatic dl_write(input logic [7:0] index, input logic [24:0] addr,
                                input port_byte_t data);
                dl_wr    = 1'b1;
                dl_index = index;
                dl_addr  = addr;
                dl_data  = data;
                next_cycle();
                dl_wr    = 1'b0;
        endtask

        task automatic send_key(input logic [8:0] code, input logic pressed);
                ps2_key = '{toggle: ~ps2_key.toggle, pressed: pressed, code: code};
                next_cycle();
        endtask

        task automatic set_joy(input int player, input joy_t value);
                case (player)
                0: joystick_0 = value;
                1: joystick_1 = value;
                2: joystick_2 = value;
                default: joystick_3 = value;
                endcase
        endtask

        function automatic joy_t random_joy();
                logic [31:0] r;
                r = $urandom;
                return r[15:0];
        endfunction

        // Rampage stick byte: fire B, fire A, left, down, right, up
        function automatic port_byte_t rampage_stick(input joy_t j);
                return ~{2'b00, j[`JOY_FIRE_B_BIT], j[`JOY_FIRE_A_BIT], j[`JOY_LEFT_BIT],
                         j[`JOY_DOWN_BIT], j[`JOY_RIGHT_BIT], j[`JOY_UP_BIT]};
        endfunction

        function automatic port_byte_t sarge_pair(input joy_t a, input joy_t b);
                logic fa;
                logic fb;
                fa = a[`JOY_FIRE_A_BIT] | a[`JOY_FIRE_B_BIT];
                fb = b[`JOY_FIRE_A_BIT] | b[`JOY_FIRE_B_BIT];
                return ~{fa, fa, fb, fb, a[`JOY_DOWN_BIT], a[`JOY_UP_BIT],
                         b[`JOY_DOWN_BIT], b[`JOY_UP_BIT]};
        endfunction

        // ==============================
        // Directed tests
        // ==============================
        task automatic config_defaults();
                apply_reset();
                check_flag("sounds_good", sounds_good, 1'b1);   // Rampage
                check_port("input3", input3, 8'hFF);
                check_port("input0", input0, 8'hFF);
                dl_write(8'd254, 25'd0, 8'h5A);
                check_port("input3", input3, 8'h5A);
                dl_write(8'd254, 25'd1, 8'h00);                 // Unused DIP byte
                check_port("input3", input3, 8'h5A);
                for (int g = 3; g >= 0; g--) begin
                        dl_write(8'd1, 25'd0, 8'(g));
                        check_flag("sounds_good", sounds_good, (g == 0) || (g == 2));
                        check_port("input3", input3, 8'h5A);
                end
        endtask

        task automatic rampage_controls();
                logic [8:0] codes [6] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
                                          `KEY_SPACE, `KEY_ALT};
                int         bits [6] = '{0, 2, 3, 1, 4, 5};
                joy_t       j [3];
                apply_reset();
                for (int k = 0; k < 6; k++) begin
                        send_key(codes[k], 1'b1);
                        check_port("input1", input1, ~(8'h01 << bits[k]));
                        check_port("input2", input2, 8'hFF);
                        send_key(codes[k], 1'b0);
                        check_port("input1", input1, 8'hFF);
                end
                send_key(`KEY_R, 1'b1);                         // Player 2 up
                check_port("input2", input2, 8'hFE);
                send_key(`KEY_R, 1'b0);
                send_key(`KEY_ESC, 1'b1);
                check_port("input0", input0, 8'hFC);            // Coin for both
                send_key(`KEY_ESC, 1'b0);
                check_port("input0", input0, 8'hFF);
                for (int p = 0; p < 3; p++) begin
                        j[p] = random_joy();
                        set_joy(p, j[p]);
                end
                service = 1'b1;
                next_cycle();
                check_port("input0", input0, ~{2'b00, 1'b1, 3'b000, j[1][`JOY_COIN_BIT],
                                               j[0][`JOY_COIN_BIT]});
                check_port("input1", input1, rampage_stick(j[0]));
                check_port("input2", input2, rampage_stick(j[1]));
                check_port("input4", input4, rampage_stick(j[2]));
        endtask

        task automatic sarge_layout();
                joy_t j [4];
                apply_reset();
                dl_write(8'd1, 25'd0, 8'd1);
                for (int n = 0; n < 8; n++) begin
                        for (int p = 0; p < 4; p++) begin
                                j[p] = random_joy();
                                set_joy(p, j[p]);
                        end
                        service = j[0][15];
                        next_cycle();
                        check_port("input0", input0, ~{2'b00, service, 1'b0,
                                   j[1][`JOY_START_BIT], j[0][`JOY_START_BIT],
                                   j[1][`JOY_COIN_BIT], j[0][`JOY_COIN_BIT]});
                        check_port("input1", input1, sarge_pair(j[0], j[1]));
                        check_port("input2", input2, sarge_pair(j[2], j[3]));
                        check_port("input4", input4, 8'hFF);
                        check_flag("sounds_good", sounds_good, 1'b0);
                end
        endtask

        task automatic maxrpm_press(input int player, input int bit_pos);
                joy_t j;
                logic start;
                j = '0;
                j[bit_pos] = 1'b1;
                start = (bit_pos == `JOY_START_BIT);
                set_joy(player, j);
                next_cycle();
                if (start)
                        rpm_gear[player] = 0;
                else if (bit_pos == `JOY_FIRE_A_BIT && rpm_gear[player] < 4)
                        rpm_gear[player]++;
                else if (bit_pos == `JOY_FIRE_B_BIT && rpm_gear[player] > 0)
                        rpm_gear[player]--;
                check_port("input2", input2, ~{rpm_code[rpm_gear[0]], rpm_code[rpm_gear[1]]});
                check_port("input0", input0, ~{4'b0000, start && player == 0,
                                               start && player == 1, 2'b00});
                next_cycle();   // Still held, no second step
                check_port("input2", input2, ~{rpm_code[rpm_gear[0]], rpm_code[rpm_gear[1]]});
                set_joy(player, '0);
                next_cycle();
                check_port("input2", input2, ~{rpm_code[rpm_gear[0]], rpm_code[rpm_gear[1]]});
        endtask

        task automatic maxrpm_gears();
                apply_reset();
                rpm_gear = '{0, 0};
                dl_write(8'd1, 25'd0, 8'd3);
                check_port("input1", input1, 8'hFF);            // No pedals
                check_port("input2", input2, 8'hFF);
                for (int n = 0; n < 6; n++)
                        maxrpm_press(0, `JOY_FIRE_A_BIT);       // Saturates at gear 4
                maxrpm_press(1, `JOY_FIRE_A_BIT);
                for (int n = 0; n < 6; n++)
                        maxrpm_press(0, `JOY_FIRE_B_BIT);
                maxrpm_press(0, `JOY_FIRE_A_BIT);
                maxrpm_press(0, `JOY_FIRE_A_BIT);
                maxrpm_press(0, `JOY_START_BIT);
                maxrpm_press(1, `JOY_START_BIT);
        endtask

        task automatic powerdrive_gears();
                int order [4] = '{0, 1, 2, 0};
                apply_reset();
                pd_gear = 3'b000;
                dl_write(8'd1, 25'd0, 8'd2);
                snd_stat = 2'b01;
                next_cycle();
                check_port("input2", input2, 8'h7F);
                snd_stat = 2'b10;
                for (int k = 0; k < 4; k++) begin
                        set_joy(order[k], joy_t'(1) << `JOY_FIRE_D_BIT);
                        next_cycle();
                        pd_gear[order[k]] = ~pd_gear[order[k]];
                        check_port("input1", input1,
                                   ~{2'b00, pd_gear[1], 3'b000, pd_gear[0], 1'b0});
                        check_port("input2", input2, ~{4'b0000, 2'b00, pd_gear[2], 1'b0});
                        next_cycle();
                        set_joy(order[k], '0);
                        next_cycle();
                        check_port("input1", input1,
                                   ~{2'b00, pd_gear[1], 3'b000, pd_gear[0], 1'b0});
                end
        endtask

        initial begin
                err_port    = 0;
                err_flag    = 0;
                err_timeout = 0;
                void'($urandom(32'h2c85_4611));
                reset      = 1'b1;
                ps2_key    = '0;
                joystick_0 = '0;
                joystick_1 = '0;
                joystick_2 = '0;
                joystick_3 = '0;
                dl_wr      = 1'b0;
                dl_index   = '0;
                dl_addr    = '0;
                dl_data    = '0;
                service    = 1'b0;
                snd_stat   = 2'b00;
                config_defaults();
                rampage_controls();
                sarge_layout();
                maxrpm_gears();
                powerdrive_gears();
                $display("Errors: %0d port, %0d flag, %0d timeout", err_port, err_flag,
                         err_timeout);
                if (err_port + err_flag + err_timeout == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

endmodule

//--- mcr3_input_top.f
+incdir+design
design/mcr3_ctrl_pkg.sv
design/mcr3_game_pkg.sv
design/control_merge.sv
design/game_config.sv
design/port_mapper.sv
design/mcr3_input_top.sv
dv/mcr3_input_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the input front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -f mcr3_input_top.f \
        --top-module mcr3_input_tb -o mcr3_input_sim
if [ $? -ne 0 ]; then
        echo "Verilator compile failed"
        exit 1
fi

./obj_dir/mcr3_input_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
        exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
        echo "No result line found in $LOG"
        exit 1
fi
exit 0
